/* logic/cam_settings.svh */
// camera subsystem settings
// frame geometry, scan blanking, detection limit and reset thresholds
`ifndef CAM_SETTINGS_SVH
`define CAM_SETTINGS_SVH

// reduced frame, active area
`define CAM_H_ACTIVE 32
`define CAM_V_ACTIVE 24

// full scan lengths incl. blanking
`define CAM_H_TOTAL 40
`define CAM_V_TOTAL 28

// sync pulses, placed inside blanking
`define CAM_HSYNC_START 34
`define CAM_HSYNC_LEN 4
`define CAM_VSYNC_START 25
`define CAM_VSYNC_LEN 2

// frame buffer address width
`define CAM_ADDR_W 10

// fewest orange pixels that count as a target
`define DETECT_MIN_PIXELS 8

// orange window after reset
`define THRESH_RESET_R_MIN 8'hc0
`define THRESH_RESET_G_MIN 8'h40
`define THRESH_RESET_G_MAX 8'hb0
`define THRESH_RESET_B_MAX 8'h50

`endif

/* logic/cam_pkg.sv */
// camera subsystem types
// pixel formats, thresholds, scan control, buffer writes and status
`include "cam_settings.svh"

package cam_pkg;

  // camera native pixel, one nibble per colour
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pix444_t;

  // display pixel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pix888_t;

  // register layout, r_min in the top byte
  typedef struct packed {
    logic [7:0] r_min;
    logic [7:0] g_min;
    logic [7:0] g_max;
    logic [7:0] b_max;
  } orange_thresh_t;

  // scan control, travels alongside the pixel
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       de;
    logic [4:0] x;
    logic [4:0] y;
    logic       frame_end;
  } scan_ctrl_t;

  // idle scan, syncs inactive high
  localparam scan_ctrl_t SCAN_IDLE = '{hsync: 1'b1, vsync: 1'b1, default: '0};

  typedef enum logic [1:0] {
    dir_none,
    dir_left,
    dir_center,
    dir_right
  } direction_t;

  typedef struct packed {
    logic       detected;
    direction_t direction;
    logic [7:0] frame_count;
  } target_status_t;

  // one frame buffer write
  typedef struct packed {
    logic                   we;
    logic [`CAM_ADDR_W-1:0] addr;
    pix444_t                data;
  } cam_write_t;

endpackage

/* logic/ov7670_capture.sv */
// camera capture
// packs href-qualified byte pairs into 12-bit RGB444 words
// and issues frame buffer writes with a running address
`timescale 1ns/1ps
`include "cam_settings.svh"

module ov7670_capture (
  input  logic                clk_25_vga,
  input  logic                rst_n,
  input  logic                vsync,
  input  logic                href,
  input  logic [7:0]          d,
  output cam_pkg::cam_write_t wr
);
  import cam_pkg::*;

  // high while waiting for the second byte
  logic                   phase;
  logic [`CAM_ADDR_W-1:0] addr_cnt;
  logic                   we_q;
  // payload side
  logic [3:0]             red_q;
  logic [`CAM_ADDR_W-1:0] addr_q;
  pix444_t                data_q;

  // control: byte phase, write strobe, address counter
  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= 1'b0;
      addr_cnt <= '0;
      we_q     <= 1'b0;
    end else if (vsync) begin
      // frame restart
      phase    <= 1'b0;
      addr_cnt <= '0;
      we_q     <= 1'b0;
    end else begin
      we_q <= href && phase;
      if (href) begin
        phase <= !phase;
        if (phase)
          addr_cnt <= addr_cnt + 1'b1;
      end
    end
  end

  // byte latching and word assembly
  always_ff @(posedge clk_25_vga) begin
    if (href && !phase)
      red_q <= d[3:0];
    if (href && phase) begin
      // second byte carries green in the high nibble
      data_q <= '{r: red_q, g: d[7:4], b: d[3:0]};
      addr_q <= addr_cnt;
    end
  end

  assign wr = '{we: we_q, addr: addr_q, data: data_q};

  // camera must not deliver more pixels than the frame holds
  a_wr_in_frame: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
    wr.we |-> (wr.addr < `CAM_H_ACTIVE * `CAM_V_ACTIVE));

endmodule

/* logic/frame_buffer.sv */
// frame buffer
// simple dual-port RAM, single clock, one-cycle registered read
`timescale 1ns/1ps
`include "cam_settings.svh"

module frame_buffer (
  input  logic                   clk_25_vga,
  input  cam_pkg::cam_write_t    wr,
  input  logic [`CAM_ADDR_W-1:0] rd_addr,
  output cam_pkg::pix444_t       rd_data
);
  import cam_pkg::*;

  // full address space, reads past the frame stay in range
  localparam int DEPTH = 2 ** `CAM_ADDR_W;

  pix444_t mem [DEPTH];

  // write port, from capture
  always_ff @(posedge clk_25_vga) begin
    if (wr.we)
      mem[wr.addr] <= wr.data;
  end

  // read port, old data on a same-address collision
  always_ff @(posedge clk_25_vga) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* logic/vga_timing.sv */
// display scan generator
// counters, active-low syncs, de, pixel coordinates, frame_end
// and the matching frame buffer read address, all registered
`timescale 1ns/1ps
`include "cam_settings.svh"

module vga_timing (
  input  logic                   clk_25_vga,
  input  logic                   rst_n,
  output cam_pkg::scan_ctrl_t    scan,
  output logic [`CAM_ADDR_W-1:0] rd_addr
);
  import cam_pkg::*;

  localparam int HW = $clog2(`CAM_H_TOTAL);
  localparam int VW = $clog2(`CAM_V_TOTAL);

  logic [HW-1:0]          h_cnt;
  logic [VW-1:0]          v_cnt;
  logic                   h_last;
  logic                   v_last;
  logic                   active;
  // pixel index of the current position
  logic [`CAM_ADDR_W-1:0] addr_cnt;

  assign h_last = (h_cnt == `CAM_H_TOTAL - 1);
  assign v_last = (v_cnt == `CAM_V_TOTAL - 1);
  assign active = (h_cnt < `CAM_H_ACTIVE) && (v_cnt < `CAM_V_ACTIVE);

  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt    <= '0;
      v_cnt    <= '0;
      addr_cnt <= '0;
      rd_addr  <= '0;
      scan     <= SCAN_IDLE;
    end else begin
      // raster counters
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
      // running read address, restarts with the frame
      if (h_last && v_last)
        addr_cnt <= '0;
      else if (active)
        addr_cnt <= addr_cnt + 1'b1;
      rd_addr <= addr_cnt;
      // syncs are low during their pulse
      scan.hsync <= !((h_cnt >= `CAM_HSYNC_START) &&
                      (h_cnt < `CAM_HSYNC_START + `CAM_HSYNC_LEN));
      scan.vsync <= !((v_cnt >= `CAM_VSYNC_START) &&
                      (v_cnt < `CAM_VSYNC_START + `CAM_VSYNC_LEN));
      scan.de    <= active;
      scan.x     <= h_cnt[4:0];
      scan.y     <= v_cnt[4:0];
      // last active pixel of the frame
      scan.frame_end <= (h_cnt == `CAM_H_ACTIVE - 1) && (v_cnt == `CAM_V_ACTIVE - 1);
    end
  end

endmodule

/* logic/target_finder.sv */
// orange target finder
// widens RGB444 to RGB888, tests the orange window, optionally
// paints hits in the marker colour, keeps scan control aligned
`timescale 1ns/1ps

module target_finder (
  input  logic                    clk_25_vga,
  input  logic                    rst_n,
  input  cam_pkg::pix444_t        pix_in,
  input  cam_pkg::scan_ctrl_t     scan_in,
  input  cam_pkg::orange_thresh_t thresh,
  input  logic                    highlight_en,
  output cam_pkg::pix888_t        pix_out,
  output cam_pkg::scan_ctrl_t     scan_out,
  output logic                    is_orange
);
  import cam_pkg::*;

  // full red plus full blue
  localparam pix888_t MARKER = '{r: 8'hff, g: 8'h00, b: 8'hff};

  // scan delayed to match the buffer read latency
  scan_ctrl_t scan_d1;
  pix888_t    wide;
  logic       orange_c;

  // nibble replicated into both halves
  assign wide = '{r: {pix_in.r, pix_in.r},
                  g: {pix_in.g, pix_in.g},
                  b: {pix_in.b, pix_in.b}};

  // orange window, g bounds inclusive
  assign orange_c = scan_d1.de &&
                    (wide.r >= thresh.r_min) &&
                    (wide.g >= thresh.g_min) &&
                    (wide.g <= thresh.g_max) &&
                    (wide.b <= thresh.b_max);

  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      scan_d1   <= SCAN_IDLE;
      scan_out  <= SCAN_IDLE;
      is_orange <= 1'b0;
      pix_out   <= '0;
    end else begin
      scan_d1   <= scan_in;
      scan_out  <= scan_d1;
      is_orange <= orange_c;
      // blank outside the active area
      if (!scan_d1.de)
        pix_out <= '0;
      else if (highlight_en && orange_c)
        pix_out <= MARKER;
      else
        pix_out <= wide;
    end
  end

endmodule

/* logic/classification.sv */
// target classifier
// counts orange pixels per column third over a frame and
// reports detection and direction once per frame
`timescale 1ns/1ps
`include "cam_settings.svh"

module classification (
  input  logic                    clk_25_vga,
  input  logic                    rst_n,
  input  cam_pkg::scan_ctrl_t     scan,
  input  logic                    is_orange,
  output cam_pkg::target_status_t status
);
  import cam_pkg::*;

  localparam int THIRD = `CAM_H_ACTIVE / 3;
  localparam int CNT_W = `CAM_ADDR_W;

  logic [CNT_W-1:0] cnt_l, cnt_c, cnt_r;
  logic             hit;
  logic             in_l, in_r;
  // counts including the current pixel
  logic [CNT_W-1:0] sum_l, sum_c, sum_r;
  logic [CNT_W+1:0] total;
  logic             detected_c;
  direction_t       dir_c;

  assign hit  = scan.de && is_orange;
  assign in_l = scan.x < THIRD;
  assign in_r = scan.x >= 2 * THIRD;

  assign sum_l = cnt_l + CNT_W'(hit && in_l);
  assign sum_c = cnt_c + CNT_W'(hit && !in_l && !in_r);
  assign sum_r = cnt_r + CNT_W'(hit && in_r);
  assign total = (CNT_W+2)'(sum_l) + (CNT_W+2)'(sum_c) + (CNT_W+2)'(sum_r);
  assign detected_c = total >= `DETECT_MIN_PIXELS;

  // largest third wins, ties to centre first, then left
  always_comb begin
    if (!detected_c)
      dir_c = dir_none;
    else if (sum_c >= sum_l && sum_c >= sum_r)
      dir_c = dir_center;
    else if (sum_l >= sum_r)
      dir_c = dir_left;
    else
      dir_c = dir_right;
  end

  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      cnt_l  <= '0;
      cnt_c  <= '0;
      cnt_r  <= '0;
      status <= '0;
    end else if (scan.frame_end) begin
      // frame closes, publish and restart
      status.detected    <= detected_c;
      status.direction   <= dir_c;
      status.frame_count <= status.frame_count + 8'd1;
      cnt_l <= '0;
      cnt_c <= '0;
      cnt_r <= '0;
    end else begin
      cnt_l <= sum_l;
      cnt_c <= sum_c;
      cnt_r <= sum_r;
    end
  end

  // each published decision is consistent
  a_dir_matches_detect: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
    scan.frame_end |=> (status.detected != (status.direction == dir_none)));

endmodule

/* logic/cam_regs.sv */
// host register file, Wishbone classic slave
// word 0 control, word 1 orange thresholds, word 2 status (ro)
`timescale 1ns/1ps
`include "cam_settings.svh"

module cam_regs (
  input  logic                    clk_25_vga,
  input  logic                    rst_n,
  input  logic                    wb_cyc,
  input  logic                    wb_stb,
  input  logic                    wb_we,
  input  logic [1:0]              wb_adr,
  input  logic [31:0]             wb_dat_w,
  output logic [31:0]             wb_dat_r,
  output logic                    wb_ack,
  input  cam_pkg::target_status_t status,
  output cam_pkg::orange_thresh_t thresh,
  output logic                    highlight_en
);
  import cam_pkg::*;

  // new request, not the tail of one already acked
  logic access;

  assign access = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk_25_vga or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack       <= 1'b0;
      wb_dat_r     <= '0;
      highlight_en <= 1'b0;
      thresh       <= '{r_min: `THRESH_RESET_R_MIN, g_min: `THRESH_RESET_G_MIN,
                        g_max: `THRESH_RESET_G_MAX, b_max: `THRESH_RESET_B_MAX};
    end else begin
      // single-cycle ack, no wait states
      wb_ack <= access;
      if (access && wb_we) begin
        case (wb_adr)
          2'd0: highlight_en <= wb_dat_w[0];
          2'd1: thresh <= orange_thresh_t'(wb_dat_w);
          default: ;
        endcase
      end
      // read data, undefined words read zero
      if (access) begin
        case (wb_adr)
          2'd0: wb_dat_r <= {31'd0, highlight_en};
          2'd1: wb_dat_r <= thresh;
          2'd2: wb_dat_r <= 32'(status);
          default: wb_dat_r <= '0;
        endcase
      end
    end
  end

  // ack only inside a bus cycle
  a_ack_in_cycle: assert property (@(posedge clk_25_vga) disable iff (!rst_n)
    wb_ack |-> wb_cyc);

endmodule

/* logic/top_level.sv */
// camera-to-display and target detection subsystem
// capture, frame buffer, scan, pixel test, classifier, host registers
`timescale 1ns/1ps
`include "cam_settings.svh"

module top_level (
  input  logic             clk_25_vga,
  input  logic             rst_n,
  // camera
  input  logic             ov7670_vsync,
  input  logic             ov7670_href,
  input  logic [7:0]       ov7670_data,
  // display
  output logic             vga_hsync,
  output logic             vga_vsync,
  output logic             vga_de,
  output cam_pkg::pix888_t vga_rgb,
  // host bus
  input  logic             wb_cyc,
  input  logic             wb_stb,
  input  logic             wb_we,
  input  logic [1:0]       wb_adr,
  input  logic [31:0]      wb_dat_w,
  output logic [31:0]      wb_dat_r,
  output logic             wb_ack
);
  import cam_pkg::*;

  cam_write_t             cam_wr;
  scan_ctrl_t             scan_raw;
  scan_ctrl_t             scan_vid;
  logic [`CAM_ADDR_W-1:0] rd_addr;
  pix444_t                rd_data;
  orange_thresh_t         thresh;
  logic                   highlight_en;
  logic                   is_orange;
  target_status_t         status;

  // display pins from the aligned scan
  assign vga_hsync = scan_vid.hsync;
  assign vga_vsync = scan_vid.vsync;
  assign vga_de    = scan_vid.de;

  ov7670_capture u_capture (.clk_25_vga, .rst_n, .vsync(ov7670_vsync), .href(ov7670_href),
    .d(ov7670_data), .wr(cam_wr));

  frame_buffer u_frame_buffer (.clk_25_vga, .wr(cam_wr), .rd_addr, .rd_data);

  vga_timing u_vga_timing (.clk_25_vga, .rst_n, .scan(scan_raw), .rd_addr);

  target_finder u_target_finder (.clk_25_vga, .rst_n, .pix_in(rd_data), .scan_in(scan_raw),
    .thresh, .highlight_en, .pix_out(vga_rgb), .scan_out(scan_vid), .is_orange);

  classification u_classification (.clk_25_vga, .rst_n, .scan(scan_vid), .is_orange,
    .status);

  cam_regs u_cam_regs (.clk_25_vga, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
    .wb_dat_r, .wb_ack, .status, .thresh, .highlight_en);

endmodule

/* tests/tb_model.svh */
// testbench model and bus helpers for the camera subsystem
// frame model, orange rule, status prediction, Wishbone and camera drivers
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int FRAME_PIX = `CAM_H_ACTIVE * `CAM_V_ACTIVE;
localparam int THIRD_W = `CAM_H_ACTIVE / 3;
localparam pix888_t MARKER_PIX = '{r: 8'hff, g: 8'h00, b: 8'hff};
// clearly inside the reset orange window
localparam pix444_t ORANGE_PIX = '{r: 4'hf, g: 4'h8, b: 4'h2};

pix444_t        model_frame [FRAME_PIX];
orange_thresh_t th_model;
int             checks = 0;
int             errors = 0;
integer         seed = 28915;

function automatic pix888_t widen(input pix444_t p);
  return '{r: {p.r, p.r}, g: {p.g, p.g}, b: {p.b, p.b}};
endfunction

function automatic logic is_orange_px(input pix444_t p, input orange_thresh_t th);
  pix888_t w;
  w = widen(p);
  return (w.r >= th.r_min) && (w.g >= th.g_min) && (w.g <= th.g_max) && (w.b <= th.b_max);
endfunction

// red nibble kept below c, so never orange under the reset window
function automatic pix444_t rand_bg();
  logic [31:0] v;
  v = $random(seed);
  return '{r: v[3:0] % 4'd12, g: v[7:4], b: v[11:8]};
endfunction

// {detected, direction} predicted from the whole model frame
function automatic logic [2:0] exp_status(input orange_thresh_t th);
  int         n_l;
  int         n_c;
  int         n_r;
  int         x;
  logic       det;
  direction_t d;
  n_l = 0;
  n_c = 0;
  n_r = 0;
  for (int i = 0; i < FRAME_PIX; i++) begin
    x = i % `CAM_H_ACTIVE;
    if (is_orange_px(model_frame[i], th)) begin
      if (x < THIRD_W) n_l++;
      else if (x >= 2 * THIRD_W) n_r++;
      else n_c++;
    end
  end
  det = (n_l + n_c + n_r) >= `DETECT_MIN_PIXELS;
  if (!det) d = dir_none;
  else if (n_c >= n_l && n_c >= n_r) d = dir_center;
  else if (n_l >= n_r) d = dir_left;
  else d = dir_right;
  return {det, d};
endfunction

task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
  checks++;
  if (expected !== actual) begin
    errors++;
    $display("ERROR at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
  end
endtask

task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
  @(posedge clk_25_vga);
  #2;
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we = 1'b1;
  wb_adr = adr;
  wb_dat_w = data;
  @(negedge clk_25_vga);
  while (!wb_ack) @(negedge clk_25_vga);
  @(posedge clk_25_vga);
  #2;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
  wb_we = 1'b0;
endtask

task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
  @(posedge clk_25_vga);
  #2;
  wb_cyc = 1'b1;
  wb_stb = 1'b1;
  wb_we = 1'b0;
  wb_adr = adr;
  @(negedge clk_25_vga);
  while (!wb_ack) @(negedge clk_25_vga);
  data = wb_dat_r;
  @(posedge clk_25_vga);
  #2;
  wb_cyc = 1'b0;
  wb_stb = 1'b0;
endtask

// vsync pulse, then n model pixels as byte pairs with href held high
task automatic cam_send(input int n);
  logic [31:0] junk;
  @(posedge clk_25_vga);
  #2;
  ov7670_vsync = 1'b1;
  @(posedge clk_25_vga);
  #2;
  ov7670_vsync = 1'b0;
  for (int i = 0; i < n; i++) begin
    junk = $random(seed);
    @(posedge clk_25_vga);
    #2;
    ov7670_href = 1'b1;
    // top nibble of the first byte is unused
    ov7670_data = {junk[3:0], model_frame[i].r};
    @(posedge clk_25_vga);
    #2;
    ov7670_data = {model_frame[i].g, model_frame[i].b};
  end
  @(posedge clk_25_vga);
  #2;
  ov7670_href = 1'b0;
  // last write lands one cycle later
  repeat (2) @(posedge clk_25_vga);
endtask

`endif

/* tests/tb_top_level.sv */
// testbench for the camera subsystem top level
// drives camera frames and host accesses, checks display and status
`timescale 1ns/1ps
`include "cam_settings.svh"

module tb_top_level;
  import cam_pkg::*;

  localparam int TIMEOUT_CYCLES = 12 * `CAM_H_TOTAL * `CAM_V_TOTAL + 2000;

  logic        clk_25_vga;
  logic        rst_n;
  logic        ov7670_vsync;
  logic        ov7670_href;
  logic [7:0]  ov7670_data;
  logic        vga_hsync;
  logic        vga_vsync;
  logic        vga_de;
  pix888_t     vga_rgb;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  int          cycles = 0;

  `include "tb_model.svh"

  top_level dut_i (.*);

  initial begin
    clk_25_vga = 1'b0;
    forever #20 clk_25_vga = ~clk_25_vga;
  end

  // run limit
  always @(posedge clk_25_vga) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic wait_vsync_fall();
    @(negedge clk_25_vga);
    while (!vga_vsync) @(negedge clk_25_vga);
    while (vga_vsync) @(negedge clk_25_vga);
  endtask

  // one whole display frame, from sync end to next sync start
  task automatic collect_frame(input logic hl);
    int      idx;
    int      pos;
    int      col;
    int      row;
    logic    exp_hs;
    pix888_t exp_pix;
    idx = 0;
    pos = 0;
    @(negedge clk_25_vga);
    while (vga_vsync) @(negedge clk_25_vga);
    while (!vga_vsync) @(negedge clk_25_vga);
    while (vga_vsync) begin
      // scan position, first sample is the line after the sync pulse
      col = pos % `CAM_H_TOTAL;
      row = (`CAM_VSYNC_START + `CAM_VSYNC_LEN + pos / `CAM_H_TOTAL) % `CAM_V_TOTAL;
      // hsync low only inside its pulse
      exp_hs = !((col >= `CAM_HSYNC_START) && (col < `CAM_HSYNC_START + `CAM_HSYNC_LEN));
      check("hsync", 32'(exp_hs), 32'(vga_hsync));
      check("de", 32'((col < `CAM_H_ACTIVE) && (row < `CAM_V_ACTIVE)), 32'(vga_de));
      if (vga_de) begin
        exp_pix = '0;
        if (idx < FRAME_PIX)
          exp_pix = (hl && is_orange_px(model_frame[idx], th_model)) ?
                    MARKER_PIX : widen(model_frame[idx]);
        check($sformatf("pixel %0d", idx), 32'(exp_pix), 32'(vga_rgb));
        idx++;
      end else begin
        check("blank pixel", 32'd0, 32'(vga_rgb));
      end
      pos++;
      @(negedge clk_25_vga);
    end
    check("de pixels per frame", 32'(FRAME_PIX), 32'(idx));
    check("cycles between vsync pulses",
          32'((`CAM_V_TOTAL - `CAM_VSYNC_LEN) * `CAM_H_TOTAL), 32'(pos));
  endtask

  // orange pixels in row 0 per third, rest of rows 0 and 1 background
  task automatic direction_frame(input int n_l, input int n_c, input int n_r,
                                 inout logic [7:0] cnt);
    logic [31:0] rd;
    for (int i = 0; i < 2 * `CAM_H_ACTIVE; i++)
      model_frame[i] = rand_bg();
    for (int k = 0; k < n_l; k++) model_frame[k] = ORANGE_PIX;
    for (int k = 0; k < n_c; k++) model_frame[THIRD_W + k] = ORANGE_PIX;
    for (int k = 0; k < n_r; k++) model_frame[2 * THIRD_W + k] = ORANGE_PIX;
    // written during blanking, ahead of the display scan
    cam_send(2 * `CAM_H_ACTIVE);
    wait_vsync_fall();
    wb_read(2'd2, rd);
    check("detected and direction", 32'(exp_status(th_model)), 32'(rd[10:8]));
    check("frame count", 32'(cnt + 8'd1), 32'(rd[7:0]));
    cnt = rd[7:0];
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("test %s done, %0d errors", name, errors - errs_before);
  endtask

  initial begin
    int          e0;
    logic [31:0] rd;
    logic [7:0]  cnt;
    rst_n = 1'b0;
    ov7670_vsync = 1'b0;
    ov7670_href = 1'b0;
    ov7670_data = '0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    th_model = '{r_min: `THRESH_RESET_R_MIN, g_min: `THRESH_RESET_G_MIN,
                 g_max: `THRESH_RESET_G_MAX, b_max: `THRESH_RESET_B_MAX};
    repeat (4) @(posedge clk_25_vga);
    #2;
    rst_n = 1'b1;

    e0 = errors;
    wb_read(2'd0, rd);
    check("control after reset", 32'd0, rd);
    wb_read(2'd1, rd);
    check("thresholds after reset", 32'(th_model), rd);
    wb_read(2'd2, rd);
    check("status after reset", 32'd0, rd);
    wb_write(2'd0, 32'd1);
    wb_read(2'd0, rd);
    check("control readback", 32'd1, rd);
    wb_write(2'd1, 32'ha1b2c3d4);
    wb_read(2'd1, rd);
    check("threshold readback", 32'ha1b2c3d4, rd);
    wb_read(2'd3, rd);
    check("undefined address", 32'd0, rd);
    wb_write(2'd0, 32'd0);
    end_test("register access", e0);

    // random frame, highlight off
    e0 = errors;
    for (int i = 0; i < FRAME_PIX; i++)
      model_frame[i] = rand_bg();
    cam_send(FRAME_PIX);
    collect_frame(1'b0);
    end_test("capture and display", e0);

    // wider window so some random pixels match
    e0 = errors;
    th_model = '{r_min: 8'h80, g_min: 8'h30, g_max: 8'hc0, b_max: 8'h70};
    wb_write(2'd1, 32'(th_model));
    wb_write(2'd0, 32'd1);
    collect_frame(1'b1);
    end_test("highlight", e0);

    // back to the reset window, background never matches
    e0 = errors;
    th_model = '{r_min: `THRESH_RESET_R_MIN, g_min: `THRESH_RESET_G_MIN,
                 g_max: `THRESH_RESET_G_MAX, b_max: `THRESH_RESET_B_MAX};
    wb_write(2'd1, 32'(th_model));
    wb_write(2'd0, 32'd0);
    wb_read(2'd2, rd);
    cnt = rd[7:0];
    direction_frame(7, 2, 1, cnt);
    direction_frame(1, 8, 2, cnt);
    direction_frame(0, 3, 9, cnt);
    // left and right tie
    direction_frame(5, 0, 5, cnt);
    end_test("direction", e0);

    // below the limit, then one more frame for the count
    e0 = errors;
    direction_frame(2, 2, 1, cnt);
    wait_vsync_fall();
    wb_read(2'd2, rd);
    check("frame count over one frame", 32'(cnt + 8'd1), 32'(rd[7:0]));
    end_test("detection limit and frame count", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+logic
+incdir+tests
logic/cam_pkg.sv
logic/ov7670_capture.sv
logic/frame_buffer.sv
logic/vga_timing.sv
logic/target_finder.sv
logic/classification.sv
logic/cam_regs.sv
logic/top_level.sv
tests/tb_top_level.sv

/* run_sim.sh */
#!/bin/sh
# build and run the camera subsystem simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_top_level -f flist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
